// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing --assert
TOP       ?= tbMipsCore
FLIST     ?= flist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
BIN       := $(OBJDIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: flist.f
logic/mipsPkg.sv
logic/fetchUnit.sv
logic/decodeUnit.sv
logic/regFile.sv
logic/execUnit.sv
logic/mipsCore.sv
tb/mipsCore_sva.sv
tb/tbMipsCore.sv

// File: logic/decodeUnit.sv
// main control decode, R-type ALU operation decode and immediate sign extension
module decodeUnit import mipsPkg::*; (
  input  instr_u               instr,
  output ctrl_t                ctrl,
  output logic [dataWidth-1:0] immExt
);

  // ======================================================================
  // immediate
  // ======================================================================
  // lw, sw offset and beq displacement
  assign immExt = {{16{instr.iFields.imm16[15]}}, instr.iFields.imm16};

  // ======================================================================
  // control decode
  // ======================================================================
  always_comb begin
    // safe defaults, no side effects
    ctrl       = '0;
    ctrl.aluOp = aluNone;

    case (instr.rFields.opcode)
      opR: begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        // funct picks the operation
        case (instr.rFields.funct)
          fnAdd:   ctrl.aluOp = aluAdd;
          fnSub:   ctrl.aluOp = aluSub;
          fnAnd:   ctrl.aluOp = aluAnd;
          fnOr:    ctrl.aluOp = aluOr;
          fnSlt:   ctrl.aluOp = aluSlt;
          default: begin
            // unsupported funct, behaves as a no-op
            ctrl.aluOp    = aluNone;
            ctrl.regWrite = 1'b0;
          end
        endcase
      end

      opLw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = aluAdd;
      end

      opSw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.aluOp    = aluAdd;
      end

      // compare via subtract, zero means equal
      opBeq: begin
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub;
      end

      opJ: begin
        ctrl.jump = 1'b1;
      end

      // link write, no ALU use
      opJal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end

      default: begin
        // unknown opcode keeps the defaults
        ctrl.regWrite = 1'b0;
        ctrl.memWrite = 1'b0;
      end
    endcase
  end

endmodule

// File: logic/execUnit.sv
// ALU, branch compare, data memory request and write-back select
module execUnit import mipsPkg::*; (
  input  ctrl_t                ctrl,
  input  instr_u               instr,
  input  logic [dataWidth-1:0] rsData,
  input  logic [dataWidth-1:0] rtData,
  input  logic [dataWidth-1:0] immExt,
  input  logic [dataWidth-1:0] pcPlus4,
  input  logic [dataWidth-1:0] dmemRdData,
  output dmemReq_t             dmemReq,
  output wbTrace_t             wb,
  output logic                 branchTaken
);

  logic [dataWidth-1:0] opB;
  logic [dataWidth-1:0] aluResult;
  logic                 aluZero;

  // ======================================================================
  // ALU
  // ======================================================================
  assign opB = ctrl.aluSrc ? immExt : rtData;

  always_comb begin
    case (ctrl.aluOp)
      aluAdd:  aluResult = rsData + opB;
      aluSub:  aluResult = rsData - opB;
      aluAnd:  aluResult = rsData & opB;
      aluOr:   aluResult = rsData | opB;
      // signed compare
      aluSlt:  aluResult = {{(dataWidth-1){1'b0}}, $signed(rsData) < $signed(opB)};
      default: aluResult = '0;
    endcase
  end

  assign aluZero = (aluResult == '0);

  // beq only, sub of rs and rt
  assign branchTaken = ctrl.branch && aluZero;

  // ======================================================================
  // data memory
  // ======================================================================
  // byte address dropped to word address
  assign dmemReq.wrEn   = ctrl.memWrite;
  assign dmemReq.addr   = aluResult[dataWidth-1:2];
  assign dmemReq.wrData = rtData;

  // ======================================================================
  // write-back
  // ======================================================================
  assign wb.valid = ctrl.regWrite;

  // link beats regDst
  always_comb begin
    if (ctrl.link) begin
      wb.addr = linkReg;
    end else if (ctrl.regDst) begin
      wb.addr = instr.rFields.rd;
    end else begin
      wb.addr = instr.iFields.rt;
    end
  end

  // jal returns to the next instruction
  assign wb.data = ctrl.link     ? pcPlus4    :
                   ctrl.memToReg ? dmemRdData : aluResult;

endmodule

// File: logic/fetchUnit.sv
// program counter register with sequential, branch and jump next-address selection
module fetchUnit import mipsPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  ctrl_t                ctrl,
  input  logic                 branchTaken,
  input  instr_u               instr,
  output logic [dataWidth-1:0] pc,
  output logic [dataWidth-1:0] pcPlus4
);

  // ======================================================================
  // next address candidates
  // ======================================================================
  logic [dataWidth-1:0] branchOffset;
  logic [dataWidth-1:0] branchTarget;
  logic [dataWidth-1:0] jumpTarget;
  logic [dataWidth-1:0] pcNext;

  assign pcPlus4 = pc + 32'd4;

  // word offset, sign extended then times four
  assign branchOffset = {{14{instr.iFields.imm16[15]}}, instr.iFields.imm16, 2'b00};
  assign branchTarget = pcPlus4 + branchOffset;

  // pseudo-direct, region from pc+4
  assign jumpTarget = {pcPlus4[dataWidth-1:28], instr.jFields.target26, 2'b00};

  // jump wins over branch
  // decode never sets both anyway
  always_comb begin
    if (ctrl.jump) begin
      pcNext = jumpTarget;
    end else if (branchTaken) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  // ======================================================================
  // pc register
  // ======================================================================
  // advances every edge, no stalls
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

// File: logic/mipsCore.sv
// single-cycle core top, fetch, decode, register file and execute wiring
module mipsCore import mipsPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  output logic [dataWidth-1:0] instrAddr,
  input  instr_u               instr,
  output dmemReq_t             dmemReq,
  input  logic [dataWidth-1:0] dmemRdData,
  output wbTrace_t             wbTrace
);

  // ======================================================================
  // internal nets
  // ======================================================================
  ctrl_t                ctrl;
  logic [dataWidth-1:0] pcPlus4;
  logic [dataWidth-1:0] immExt;
  logic [dataWidth-1:0] rsData;
  logic [dataWidth-1:0] rtData;
  logic                 branchTaken;
  dmemReq_t             execReq;
  wbTrace_t             execWb;

  // ======================================================================
  // fetch
  // ======================================================================
  fetchUnit i_fetch (
    .clk         (clk),
    .rst         (rst),
    .ctrl        (ctrl),
    .branchTaken (branchTaken),
    .instr       (instr),
    .pc          (instrAddr),
    .pcPlus4     (pcPlus4)
  );

  // ======================================================================
  // decode and operands
  // ======================================================================
  decodeUnit i_decode (
    .instr  (instr),
    .ctrl   (ctrl),
    .immExt (immExt)
  );

  // write triple comes back from the reset-gated trace
  regFile i_regFile (
    .clk    (clk),
    .rst    (rst),
    .rsAddr (instr.rFields.rs),
    .rtAddr (instr.rFields.rt),
    .wrEn   (wbTrace.valid),
    .wrAddr (wbTrace.addr),
    .wrData (wbTrace.data),
    .rsData (rsData),
    .rtData (rtData)
  );

  // ======================================================================
  // execute
  // ======================================================================
  execUnit i_exec (
    .ctrl        (ctrl),
    .instr       (instr),
    .rsData      (rsData),
    .rtData      (rtData),
    .immExt      (immExt),
    .pcPlus4     (pcPlus4),
    .dmemRdData  (dmemRdData),
    .dmemReq     (execReq),
    .wb          (execWb),
    .branchTaken (branchTaken)
  );

  // no writes leave the core while rst is low
  always_comb begin
    dmemReq       = execReq;
    dmemReq.wrEn  = execReq.wrEn & rst;
    wbTrace       = execWb;
    wbTrace.valid = execWb.valid & rst;
  end

endmodule

// File: logic/mipsPkg.sv
// widths, opcode and funct codes, instruction union, control struct, ALU op enum, port structs
package mipsPkg;

  // ======================================================================
  // core widths
  // ======================================================================
  localparam int dataWidth    = 32;
  localparam int regCount     = 32;
  localparam int regAddrWidth = 5;

  // jal destination
  localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

  // ======================================================================
  // opcode field values
  // ======================================================================
  localparam logic [5:0] opR   = 6'd0;
  localparam logic [5:0] opJ   = 6'd2;
  localparam logic [5:0] opJal = 6'd3;
  localparam logic [5:0] opBeq = 6'd4;
  localparam logic [5:0] opLw  = 6'd35;
  localparam logic [5:0] opSw  = 6'd43;

  // funct field values, R-type only
  localparam logic [5:0] fnAdd = 6'h20;
  localparam logic [5:0] fnSub = 6'h22;
  localparam logic [5:0] fnAnd = 6'h24;
  localparam logic [5:0] fnOr  = 6'h25;
  localparam logic [5:0] fnSlt = 6'h2a;

  // ======================================================================
  // instruction word views
  // ======================================================================
  typedef struct packed {
    logic [5:0]              opcode;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;
    logic [4:0]              shamt;
    logic [5:0]              funct;
  } rType_t;

  typedef struct packed {
    logic [5:0]              opcode;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [15:0]             imm16;
  } iType_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target26;
  } jType_t;

  // same 32 bits, three decodings
  typedef union packed {
    rType_t rFields;
    iType_t iFields;
    jType_t jFields;
  } instr_u;

  // ======================================================================
  // control and port bundles
  // ======================================================================
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt,
    aluNone
  } aluOp_e;

  typedef struct packed {
    logic   regDst;    // dest is rd, else rt
    logic   aluSrc;    // operand b is immExt
    logic   memToReg;
    logic   regWrite;
    logic   memWrite;
    logic   branch;
    logic   jump;
    logic   link;      // jal, write pcPlus4 to linkReg
    aluOp_e aluOp;
  } ctrl_t;

  // register write-back, also the trace port
  typedef struct packed {
    logic                    valid;
    logic [regAddrWidth-1:0] addr;
    logic [dataWidth-1:0]    data;
  } wbTrace_t;

  // data memory request, word addressed
  typedef struct packed {
    logic                 wrEn;
    logic [dataWidth-3:0] addr;
    logic [dataWidth-1:0] wrData;
  } dmemReq_t;

endpackage

// File: logic/regFile.sv
// 32 x 32 register file, two combinational read ports, one write port, r0 tied to zero
module regFile import mipsPkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [regAddrWidth-1:0] rsAddr,
  input  logic [regAddrWidth-1:0] rtAddr,
  input  logic                    wrEn,
  input  logic [regAddrWidth-1:0] wrAddr,
  input  logic [dataWidth-1:0]    wrData,
  output logic [dataWidth-1:0]    rsData,
  output logic [dataWidth-1:0]    rtData
);

  logic [dataWidth-1:0] regs [regCount];

  // ======================================================================
  // write port
  // ======================================================================
  // whole array cleared on reset
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int k = 0; k < regCount; k++) begin
        regs[k] <= '0;
      end
    end else if (wrEn && (wrAddr != '0)) begin
      // r0 never written
      regs[wrAddr] <= wrData;
    end
  end

  // ======================================================================
  // read ports
  // ======================================================================
  // same-cycle write not forwarded, single-cycle core reads before the edge
  assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
  assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

endmodule

// File: tb/mipsCore_sva.sv
// concurrent assertions on the trace port, r0 reads and instruction address, bound to mipsCore
module mipsCoreSva import mipsPkg::*; (
  input logic                 clk,
  input logic                 rst,
  input logic [dataWidth-1:0] instrAddr,
  input instr_u               instr,
  input logic [dataWidth-1:0] rsData,
  input logic [dataWidth-1:0] rtData,
  input wbTrace_t             wbTrace
);

  // quiet trace while reset holds the core
  traceQuietInReset: assert property (@(posedge clk) !rst |-> !wbTrace.valid)
    else $error("trace write while reset is low");

  // whatever went to r0, the next read of r0 is zero
  zeroRegRead: assert property (@(posedge clk) disable iff (!rst)
    (wbTrace.valid && wbTrace.addr == '0) |=>
      ((instr.rFields.rs != '0 || rsData == '0) && (instr.rFields.rt != '0 || rtData == '0)))
    else $error("r0 read back non-zero after a trace write to r0");

  // pc moves in whole words only
  wordAligned: assert property (@(posedge clk) disable iff (!rst) instrAddr[1:0] == 2'b00)
    else $error("instrAddr not word aligned");

endmodule

bind mipsCore mipsCoreSva i_sva (
  .clk       (clk),
  .rst       (rst),
  .instrAddr (instrAddr),
  .instr     (instr),
  .rsData    (rsData),
  .rtData    (rtData),
  .wbTrace   (wbTrace)
);

// File: tb/tbMipsCore.sv
// testbench top with clock, reset, memory models, ISA reference model and directed tests
module tbMipsCore import mipsPkg::*; ();

  logic        clk;
  logic        rst;
  logic [31:0] instrAddr;
  logic [31:0] instrWord;
  logic [31:0] dmemRdData;
  dmemReq_t    dmemReq;
  wbTrace_t    wbTrace;

  // memories, model state, bookkeeping
  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] mMem [256];
  logic [31:0] mRegs [32];
  logic [31:0] mPc;
  logic        checking;
  int          progLen;
  int          errCount;
  int          testErrStart;
  int          passCount;
  int          failCount;
  int          seed;
  string       curTest;

  mipsCore i_dut (
    .clk        (clk),
    .rst        (rst),
    .instrAddr  (instrAddr),
    .instr      (instrWord),
    .dmemReq    (dmemReq),
    .dmemRdData (dmemRdData),
    .wbTrace    (wbTrace)
  );

  // combinational word-indexed reads
  assign instrWord  = imem[instrAddr[9:2]];
  assign dmemRdData = dmem[dmemReq.addr[7:0]];

  always @(posedge clk) begin
    if (dmemReq.wrEn) begin
      dmem[dmemReq.addr[7:0]] <= dmemReq.wrData;
    end
  end

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ====================================================================
  // instruction encoders
  // ====================================================================
  function automatic logic [31:0] rInstr(logic [5:0] fn, int rd, int rs, int rt);
    return {opR, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
  endfunction

  function automatic logic [31:0] iInstr(logic [5:0] op, int rt, int rs, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic logic [31:0] jInstr(logic [5:0] op, int target);
    return {op, 26'(target)};
  endfunction

  task automatic emit(logic [31:0] word);
    imem[progLen] = word;
    progLen++;
  endtask

  task automatic checkValue(string what, logic [31:0] expected, logic [31:0] actual);
    assert (actual === expected) else begin
      $display("error %s %s: expected %h actual %h", curTest, what, expected, actual);
      errCount++;
    end
  endtask

  task automatic checkReg(int idx, logic [31:0] expected);
    checkValue($sformatf("r%0d", idx), expected, i_dut.i_regFile.regs[idx]);
  endtask

  // ====================================================================
  // ISA reference model stepping one instruction per cycle
  // ====================================================================
  task automatic modelStep();
    logic [31:0] word;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [31:0] nextPc;
    logic [31:0] wrData;
    logic [4:0]  wrReg;
    logic        regWr;
    logic        memWr;
    word = imem[mPc[9:2]];
    a = mRegs[word[25:21]];
    b = mRegs[word[20:16]];
    imm = {{16{word[15]}}, word[15:0]};
    addr = a + imm;
    nextPc = mPc + 32'd4;
    regWr = 1'b0;
    memWr = 1'b0;
    wrReg = word[20:16];
    wrData = '0;
    case (word[31:26])
      opR: begin
        regWr = 1'b1;
        wrReg = word[15:11];
        case (word[5:0])
          fnAdd:   wrData = a + b;
          fnSub:   wrData = a - b;
          fnAnd:   wrData = a & b;
          fnOr:    wrData = a | b;
          fnSlt:   wrData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: regWr = 1'b0;
        endcase
      end
      opLw: begin
        regWr = 1'b1;
        wrData = mMem[addr[9:2]];
      end
      opSw: memWr = 1'b1;
      // offset counts words from the next instruction
      opBeq: begin
        if (a == b) begin
          nextPc = nextPc + {imm[29:0], 2'b00};
        end
      end
      opJ: nextPc = {nextPc[31:28], word[25:0], 2'b00};
      opJal: begin
        regWr = 1'b1;
        wrReg = linkReg;
        wrData = nextPc;
        nextPc = {nextPc[31:28], word[25:0], 2'b00};
      end
      default: regWr = 1'b0;
    endcase
    checkValue("instrAddr", mPc, instrAddr);
    checkValue("trace valid", {31'd0, regWr}, {31'd0, wbTrace.valid});
    if (regWr) begin
      checkValue("trace reg", {27'd0, wrReg}, {27'd0, wbTrace.addr});
      checkValue("trace data", wrData, wbTrace.data);
    end
    checkValue("mem write", {31'd0, memWr}, {31'd0, dmemReq.wrEn});
    if (memWr) begin
      checkValue("mem addr", {addr[31:2], 2'b00}, {dmemReq.addr, 2'b00});
      checkValue("mem data", b, dmemReq.wrData);
    end
    // r0 stays zero in the model too
    if (regWr && wrReg != 5'd0) begin
      mRegs[wrReg] = wrData;
    end
    if (memWr) begin
      mMem[addr[9:2]] = b;
    end
    mPc = nextPc;
  endtask

  // lockstep compare at mid-cycle while outputs are settled
  always @(negedge clk) begin
    if (checking) begin
      modelStep();
    end
  end

  // ====================================================================
  // test sequencing
  // ====================================================================
  task automatic beginTest(string name);
    checking = 1'b0;
    curTest = name;
    testErrStart = errCount;
    progLen = 0;
    // every unused word jumps to itself so runaway code halts
    for (int k = 0; k < 256; k++) begin
      imem[k] = jInstr(opJ, k);
      dmem[k] <= 32'(k) * 32'h9e37_79b1;
    end
  endtask

  task automatic runProgram();
    logic [31:0] prevAddr;
    logic        halted;
    int          cycles;
    // closing jump to itself marks the halt
    emit(jInstr(opJ, progLen));
    rst = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b1;
    mPc = '0;
    for (int k = 0; k < 256; k++) begin
      mMem[k] = dmem[k];
    end
    for (int k = 0; k < 32; k++) begin
      mRegs[k] = '0;
    end
    checking = 1'b1;
    prevAddr = instrAddr;
    halted = 1'b0;
    cycles = 0;
    while (!halted && cycles < 200) begin
      @(posedge clk);
      #1;
      halted = (instrAddr == prevAddr);
      prevAddr = instrAddr;
      cycles++;
    end
    if (!halted) begin
      $display("%s: core did not halt within 200 cycles", curTest);
      errCount++;
    end
  endtask

  task automatic endTest();
    if (errCount == testErrStart) begin
      $display("test %s passed", curTest);
      passCount++;
    end else begin
      $display("test %s failed with %0d errors", curTest, errCount - testErrStart);
      failCount++;
    end
  endtask

  // ====================================================================
  // directed tests
  // ====================================================================
  task automatic testArith();
    beginTest("arith");
    dmem[0] <= 32'd25;
    dmem[1] <= 32'hffff_fff6;
    dmem[2] <= 32'h0000_00f0;
    emit(iInstr(opLw, 1, 0, 0));
    emit(iInstr(opLw, 2, 0, 4));
    emit(iInstr(opLw, 3, 0, 8));
    emit(rInstr(fnAdd, 4, 1, 2));
    emit(rInstr(fnSub, 5, 1, 2));
    emit(rInstr(fnAnd, 6, 1, 3));
    emit(rInstr(fnOr, 7, 1, 3));
    // -10 below 25 only when signed
    emit(rInstr(fnSlt, 8, 2, 1));
    emit(rInstr(fnSlt, 9, 1, 2));
    runProgram();
    checkReg(4, 32'd15);
    checkReg(5, 32'd35);
    checkReg(6, 32'h10);
    checkReg(7, 32'hf9);
    checkReg(8, 32'd1);
    checkReg(9, 32'd0);
    endTest();
  endtask

  task automatic testLoadStore();
    beginTest("loadStore");
    dmem[4] <= 32'hcafe_f00d;
    dmem[5] <= 32'd12;
    emit(iInstr(opLw, 1, 0, 16));
    emit(iInstr(opLw, 2, 0, 20));
    // base 12 plus 36 gives word 12
    emit(iInstr(opSw, 1, 2, 36));
    emit(iInstr(opLw, 3, 2, 36));
    // negative offset lands on word 2
    emit(iInstr(opSw, 2, 2, -4));
    emit(iInstr(opLw, 4, 0, 8));
    runProgram();
    checkValue("mem[12]", 32'hcafe_f00d, dmem[12]);
    checkValue("mem[2]", 32'd12, dmem[2]);
    checkReg(3, 32'hcafe_f00d);
    checkReg(4, 32'd12);
    endTest();
  endtask

  task automatic testBranch();
    beginTest("branch");
    dmem[0] <= 32'd7;
    dmem[1] <= 32'd9;
    emit(iInstr(opLw, 1, 0, 0));
    emit(iInstr(opLw, 2, 0, 0));
    emit(iInstr(opLw, 3, 0, 4));
    // equal operands skip the add
    emit(iInstr(opBeq, 2, 1, 1));
    emit(rInstr(fnAdd, 4, 1, 2));
    emit(iInstr(opBeq, 3, 1, 1));
    emit(rInstr(fnAdd, 5, 1, 3));
    runProgram();
    checkReg(4, 32'd0);
    checkReg(5, 32'd16);
    endTest();
  endtask

  task automatic testJump();
    beginTest("jump");
    dmem[0] <= 32'd5;
    emit(jInstr(opJ, 2));
    emit(iInstr(opLw, 1, 0, 0));
    // jal at byte 8 links 12
    emit(jInstr(opJal, 5));
    emit(iInstr(opLw, 2, 0, 0));
    emit(jInstr(opJ, 4));
    emit(iInstr(opLw, 3, 0, 0));
    runProgram();
    checkReg(1, 32'd0);
    checkReg(2, 32'd0);
    checkReg(3, 32'd5);
    checkReg(31, 32'd12);
    endTest();
  endtask

  task automatic testZeroReg();
    beginTest("zeroReg");
    dmem[0] <= 32'h0000_1234;
    emit(iInstr(opLw, 1, 0, 0));
    emit(rInstr(fnAdd, 0, 1, 1));
    emit(iInstr(opLw, 0, 0, 0));
    emit(rInstr(fnOr, 2, 0, 1));
    // unknown opcode aimed at word 0 then unknown funct
    emit(iInstr(6'h3f, 3, 0, 0));
    emit(rInstr(6'h3f, 4, 1, 1));
    runProgram();
    checkReg(0, 32'd0);
    checkReg(2, 32'h1234);
    checkReg(3, 32'd0);
    checkReg(4, 32'd0);
    checkValue("mem[0]", 32'h1234, dmem[0]);
    endTest();
  endtask

  task automatic testRandom(int round);
    logic [31:0] ops [4];
    beginTest($sformatf("random%0d", round));
    for (int k = 0; k < 4; k++) begin
      ops[k] = $random(seed);
      dmem[k] <= ops[k];
      emit(iInstr(opLw, k + 1, 0, 4 * k));
    end
    emit(rInstr(fnAdd, 5, 1, 2));
    emit(rInstr(fnSub, 6, 3, 4));
    emit(rInstr(fnSlt, 7, 1, 4));
    emit(rInstr(fnSlt, 8, 4, 1));
    runProgram();
    checkReg(5, ops[0] + ops[1]);
    checkReg(6, ops[2] - ops[3]);
    checkReg(7, {31'd0, $signed(ops[0]) < $signed(ops[3])});
    checkReg(8, {31'd0, $signed(ops[3]) < $signed(ops[0])});
    endTest();
  endtask

  initial begin
    rst = 1'b0;
    checking = 1'b0;
    errCount = 0;
    passCount = 0;
    failCount = 0;
    seed = 32'h817c_c5a4;
    testArith();
    testLoadStore();
    testBranch();
    testJump();
    testZeroReg();
    for (int r = 0; r < 3; r++) begin
      testRandom(r);
    end
    $display("tests passed %0d failed %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
